/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary -Wno-fatal
TOP       ?= tbCpuTop
FILELIST  ?= cpuTop.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* alu.sv */
`default_nettype none

module alu import cpuPkg::*; (
   input  opcodeT               op,
   input  logic [WordWidth-1:0] a,
   input  logic [WordWidth-1:0] b,
   output logic [WordWidth-1:0] result,
   output logic                 equal
);

   // Shift amount from low 4 bits of b
   logic [3:0] shamt;

   assign shamt = b[3:0];

   always_comb begin
      unique case (op)
         // Address arithmetic shares the adder
         ADD, ADDI, LD, ST: begin
            result = a + b;
         end
         SUB: begin
            result = a - b;
         end
         AND: begin
            result = a & b;
         end
         OR: begin
            result = a | b;
         end
         XOR: begin
            result = a ^ b;
         end
         SHL: begin
            result = a << shamt;
         end
         // Logical, zero fill
         SHR: begin
            result = a >> shamt;
         end
         // Immediate passes straight through
         LDI: begin
            result = b;
         end
         // Branches, jumps and the rest
         default: begin
            result = '0;
         end
      endcase
   end

   // Branch decision
   assign equal = (a == b);

endmodule

`default_nettype wire

/* axiLiteManager.sv */
`default_nettype none

module axiLiteManager import cpuPkg::*; #(
   parameter int AxiAddrWidth = 18
) (
   input  logic                      clock,
   input  logic                      arstN,
   dataBusIf.responder               bus,
   output logic                      awvalid,
   input  logic                      awready,
   output logic [AxiAddrWidth-1:0]   awaddr,
   output logic                      wvalid,
   input  logic                      wready,
   output logic [AxiDataWidth-1:0]   wdata,
   output logic [AxiDataWidth/8-1:0] wstrb,
   input  logic                      bvalid,
   output logic                      bready,
   output logic                      arvalid,
   input  logic                      arready,
   output logic [AxiAddrWidth-1:0]   araddr,
   input  logic                      rvalid,
   output logic                      rready,
   input  logic [AxiDataWidth-1:0]   rdata
);

   typedef enum logic [2:0] {
      IDLE, WRITE, WRESP, READ, RRESP, DONE
   } axiStateT;

   axiStateT state;
   logic     awDone;
   logic     wDone;

   // Byte address from word address, payload held by the requester
   assign awaddr = {bus.reqAddr, 2'b00};
   assign araddr = {bus.reqAddr, 2'b00};
   assign wdata  = {{(AxiDataWidth-WordWidth){1'b0}}, bus.reqWdata};
   // Full words only
   assign wstrb  = '1;

   // Address and data channels finish on their own
   assign awDone = !awvalid || awready;
   assign wDone  = !wvalid || wready;

   // Single-cycle pulse, DONE keeps IDLE from seeing a stale request
   assign bus.reqReady = (state == DONE);

   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         state   <= IDLE;
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
         bready  <= 1'b0;
         arvalid <= 1'b0;
         rready  <= 1'b0;
      end else begin
         unique case (state)
            IDLE: begin
               if (bus.reqValid && bus.reqWrite) begin
                  awvalid <= 1'b1;
                  wvalid  <= 1'b1;
                  state   <= WRITE;
               end else if (bus.reqValid) begin
                  arvalid <= 1'b1;
                  state   <= READ;
               end
            end
            WRITE: begin
               if (awready) begin
                  awvalid <= 1'b0;
               end
               if (wready) begin
                  wvalid <= 1'b0;
               end
               if (awDone && wDone) begin
                  bready <= 1'b1;
                  state  <= WRESP;
               end
            end
            // Response code ignored
            WRESP: begin
               if (bvalid) begin
                  bready <= 1'b0;
                  state  <= DONE;
               end
            end
            READ: begin
               if (arready) begin
                  arvalid <= 1'b0;
                  rready  <= 1'b1;
                  state   <= RRESP;
               end
            end
            RRESP: begin
               if (rvalid) begin
                  rready <= 1'b0;
                  state  <= DONE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Low half of the read beat
   always_ff @(posedge clock) begin
      if ((state == RRESP) && rvalid) begin
         bus.rspRdata <= rdata[WordWidth-1:0];
      end
   end

endmodule

`default_nettype wire

/* cpuControl.sv */
`default_nettype none

module cpuControl import cpuPkg::*; #(
   parameter int RomAddrWidth = 8
) (
   input  logic                    clock,
   input  logic                    arstN,
   output logic [RomAddrWidth-1:0] romAddr,
   input  logic [WordWidth-1:0]    instr,
   output logic [RegAddrWidth-1:0] rsAddr,
   output logic [RegAddrWidth-1:0] rtAddr,
   input  logic [WordWidth-1:0]    rsData,
   input  logic [WordWidth-1:0]    rtData,
   output logic                    wrEn,
   output logic [RegAddrWidth-1:0] wrAddr,
   output logic [WordWidth-1:0]    wrData,
   output opcodeT                  aluOp,
   output logic [WordWidth-1:0]    aluA,
   output logic [WordWidth-1:0]    aluB,
   input  logic [WordWidth-1:0]    aluResult,
   input  logic                    aluEqual,
   dataBusIf.requester             bus,
   output logic                    halted
);

   localparam int ReqAddrWidth = $bits(bus.reqAddr);

   cpuStateT                state;
   logic [RomAddrWidth-1:0] pc;
   logic [WordWidth-1:0]    ir;
   opcodeT                  op;
   logic [RegAddrWidth-1:0] fieldHi;
   logic [RegAddrWidth-1:0] fieldMid;
   logic [RegAddrWidth-1:0] fieldLo;
   logic [WordWidth-1:0]    immExt;
   logic [WordWidth-1:0]    offExt;
   logic [RomAddrWidth-1:0] branchOff;
   logic [JumpWidth-1:0]    jumpTarget;
   logic                    isRegOp;
   logic                    isImmOp;
   logic                    isMemOp;
   logic                    isBranch;
   logic                    branchTaken;

   // ==============================
   // Decode
   // ==============================

   assign op = opcodeT'(ir[WordWidth-1 -: OpcodeWidth]);

   // Three register fields below the opcode
   assign fieldHi  = ir[11:9];
   assign fieldMid = ir[8:6];
   assign fieldLo  = ir[5:3];

   // Sign extension of immediate and offsets
   assign immExt    = {{(WordWidth-ImmWidth){ir[ImmWidth-1]}}, ir[ImmWidth-1:0]};
   assign offExt    = {{(WordWidth-OffsetWidth){ir[OffsetWidth-1]}}, ir[OffsetWidth-1:0]};
   assign branchOff = {{(RomAddrWidth-OffsetWidth){ir[OffsetWidth-1]}}, ir[OffsetWidth-1:0]};
   assign jumpTarget = ir[JumpWidth-1:0];

   assign isRegOp  = op inside {ADD, SUB, AND, OR, XOR, SHL, SHR};
   assign isImmOp  = op inside {ADDI, LDI};
   assign isMemOp  = op inside {LD, ST};
   assign isBranch = op inside {BEQ, BNE};

   assign branchTaken = ((op == BEQ) && aluEqual) || ((op == BNE) && !aluEqual);

   // Operand routing per format
   always_comb begin
      rsAddr = fieldMid;
      rtAddr = fieldLo;
      aluB   = rtData;
      // ADDI reads rd, branches compare rs at the top field
      if (isImmOp || isBranch) begin
         rsAddr = fieldHi;
      end
      // Store data sits in the top field
      if (isMemOp) begin
         rtAddr = fieldHi;
      end else if (isBranch) begin
         rtAddr = fieldMid;
      end
      if (isImmOp) begin
         aluB = immExt;
      end else if (isMemOp) begin
         aluB = offExt;
      end
   end

   assign aluOp = op;
   assign aluA  = rsData;

   // Destination is always the top field
   assign wrAddr = fieldHi;
   assign wrEn   = ((state == EXECUTE) && (isRegOp || isImmOp))
                 || ((state == MEMWAIT) && bus.reqReady && !bus.reqWrite);
   // Load data once the bus answers
   assign wrData = (state == MEMWAIT) ? bus.rspRdata : aluResult;

   assign romAddr = pc;
   assign halted  = (state == HALTED);

   // ==============================
   // Multicycle FSM
   // ==============================

   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         state        <= FETCH;
         pc           <= '0;
         bus.reqValid <= 1'b0;
      end else begin
         unique case (state)
            // PC now points at the next instruction
            FETCH: begin
               pc    <= pc + 1'b1;
               state <= EXECUTE;
            end
            EXECUTE: begin
               state <= FETCH;
               if (op == HALT) begin
                  state <= HALTED;
               end else if (op == JMP) begin
                  pc <= jumpTarget[RomAddrWidth-1:0];
               end else if (branchTaken) begin
                  // Relative to the next PC
                  pc <= pc + branchOff;
               end else if (isMemOp) begin
                  bus.reqValid <= 1'b1;
                  state        <= MEMWAIT;
               end
            end
            // Request held until the manager finishes
            MEMWAIT: begin
               if (bus.reqReady) begin
                  bus.reqValid <= 1'b0;
                  state        <= FETCH;
               end
            end
            // Left only by reset
            HALTED: begin
               state <= HALTED;
            end
         endcase
      end
   end

   // Instruction register and request payload
   always_ff @(posedge clock) begin
      if (state == FETCH) begin
         ir <= instr;
      end
      if ((state == EXECUTE) && isMemOp) begin
         bus.reqWrite <= (op == ST);
         bus.reqAddr  <= ReqAddrWidth'(aluResult);
         bus.reqWdata <= rtData;
      end
   end

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

   // ==============================
   // Fixed ISA widths
   // ==============================

   // Data and instruction word
   localparam int WordWidth = 16;
   // Eight general registers
   localparam int RegAddrWidth = 3;
   // Narrowest width AXI4-Lite allows
   localparam int AxiDataWidth = 32;
   // Opcode sits in the top bits
   localparam int OpcodeWidth = 4;
   // Sign-extended fields
   localparam int ImmWidth = 8;
   localparam int OffsetWidth = 6;
   // Absolute jump target
   localparam int JumpWidth = 12;

   // ==============================
   // Encodings
   // ==============================

   // Register format ops first, then immediate, memory, flow
   typedef enum logic [OpcodeWidth-1:0] {
      ADD, SUB, AND, OR, XOR, SHL, SHR,
      ADDI, LDI,
      LD, ST,
      BEQ, BNE, JMP,
      HALT, NOP
   } opcodeT;

   // Multicycle control states
   typedef enum logic [1:0] {
      FETCH, EXECUTE, MEMWAIT, HALTED
   } cpuStateT;

endpackage

`default_nettype wire

/* cpuTop.f */
cpuPkg.sv
dataBusIf.sv
programRom.sv
regFile.sv
alu.sv
cpuControl.sv
axiLiteManager.sv
cpuTop.sv
tbChecker.sv
tbCpuTop.sv

/* cpuTop.sv */
`default_nettype none

module cpuTop import cpuPkg::*; #(
   parameter int RomAddrWidth = 8,
   parameter int AxiAddrWidth = 18
) (
   input  logic                      clock,
   input  logic                      arstN,
   // AXI4-Lite manager to data memory
   output logic                      awvalid,
   input  logic                      awready,
   output logic [AxiAddrWidth-1:0]   awaddr,
   output logic                      wvalid,
   input  logic                      wready,
   output logic [AxiDataWidth-1:0]   wdata,
   output logic [AxiDataWidth/8-1:0] wstrb,
   input  logic                      bvalid,
   output logic                      bready,
   output logic                      arvalid,
   input  logic                      arready,
   output logic [AxiAddrWidth-1:0]   araddr,
   input  logic                      rvalid,
   output logic                      rready,
   input  logic [AxiDataWidth-1:0]   rdata,
   output logic                      halted
);

   logic [RomAddrWidth-1:0] romAddr;
   logic [WordWidth-1:0]    instr;
   logic [RegAddrWidth-1:0] rsAddr;
   logic [RegAddrWidth-1:0] rtAddr;
   logic [WordWidth-1:0]    rsData;
   logic [WordWidth-1:0]    rtData;
   logic                    wrEn;
   logic [RegAddrWidth-1:0] wrAddr;
   logic [WordWidth-1:0]    wrData;
   opcodeT                  aluOp;
   logic [WordWidth-1:0]    aluA;
   logic [WordWidth-1:0]    aluB;
   logic [WordWidth-1:0]    aluResult;
   logic                    aluEqual;

   // ==============================
   // Core blocks
   // ==============================

   // Load and store path between control and AXI
   dataBusIf #(.AxiAddrWidth(AxiAddrWidth)) dataBus ();

   programRom #(.RomAddrWidth(RomAddrWidth)) uProgramRom (
      .address (romAddr),
      .q       (instr)
   );

   regFile uRegFile (
      .clock  (clock),
      .arstN  (arstN),
      .rsAddr (rsAddr),
      .rtAddr (rtAddr),
      .rsData (rsData),
      .rtData (rtData),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData)
   );

   alu uAlu (
      .op     (aluOp),
      .a      (aluA),
      .b      (aluB),
      .result (aluResult),
      .equal  (aluEqual)
   );

   cpuControl #(.RomAddrWidth(RomAddrWidth)) uCpuControl (
      .clock     (clock),
      .arstN     (arstN),
      .romAddr   (romAddr),
      .instr     (instr),
      .rsAddr    (rsAddr),
      .rtAddr    (rtAddr),
      .rsData    (rsData),
      .rtData    (rtData),
      .wrEn      (wrEn),
      .wrAddr    (wrAddr),
      .wrData    (wrData),
      .aluOp     (aluOp),
      .aluA      (aluA),
      .aluB      (aluB),
      .aluResult (aluResult),
      .aluEqual  (aluEqual),
      .bus       (dataBus.requester),
      .halted    (halted)
   );

   // Data memory lives outside, reached over AXI4-Lite
   axiLiteManager #(.AxiAddrWidth(AxiAddrWidth)) uAxiLiteManager (
      .clock   (clock),
      .arstN   (arstN),
      .bus     (dataBus.responder),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .bvalid  (bvalid),
      .bready  (bready),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata)
   );

endmodule

`default_nettype wire

/* dataBusIf.sv */
`default_nettype none

interface dataBusIf import cpuPkg::*; #(
   parameter int AxiAddrWidth = 18
);

   // Request side, word address
   logic                    reqValid;
   logic                    reqWrite;
   logic [AxiAddrWidth-3:0] reqAddr;
   logic [WordWidth-1:0]    reqWdata;

   // One-cycle end of transaction, load data alongside
   logic                    reqReady;
   logic [WordWidth-1:0]    rspRdata;

   // Control unit side
   modport requester (
      output reqValid, reqWrite, reqAddr, reqWdata,
      input  reqReady, rspRdata
   );

   // AXI manager side
   modport responder (
      input  reqValid, reqWrite, reqAddr, reqWdata,
      output reqReady, rspRdata
   );

endinterface

`default_nettype wire

/* program.hex */
// One 16-bit instruction per line, hex, from address 0
// Opcode in bits 15:12, then rd/rs/rt fields, immediate or offset
8225
84F3
0650
A600
1850
A801
2A50
AA02
3C50
AC03
4E50
AE04
8403
5650
A605
69D0
A806
72FE
A207
9A10
0B48
AA08
8C0C
9F85
AF89
B241
A209
C281
A40A
B281
A40B
C241
AC0C
D023
A20D
AE0E
E000

/* programRom.sv */
`default_nettype none

module programRom import cpuPkg::*; #(
   parameter int RomAddrWidth = 8
) (
   input  logic [RomAddrWidth-1:0] address,
   output logic [WordWidth-1:0]    q
);

   localparam int RomDepth = 2**RomAddrWidth;

   logic [WordWidth-1:0] mem [RomDepth];

   // Unlisted words decode as NOP
   initial begin
      for (int i = 0; i < RomDepth; i++) begin
         mem[i] = {NOP, {(WordWidth-OpcodeWidth){1'b0}}};
      end
      $readmemh("program.hex", mem);
   end

   // Combinational read, follows the address
   assign q = mem[address];

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile import cpuPkg::*; (
   input  logic                    clock,
   input  logic                    arstN,
   input  logic [RegAddrWidth-1:0] rsAddr,
   input  logic [RegAddrWidth-1:0] rtAddr,
   output logic [WordWidth-1:0]    rsData,
   output logic [WordWidth-1:0]    rtData,
   input  logic                    wrEn,
   input  logic [RegAddrWidth-1:0] wrAddr,
   input  logic [WordWidth-1:0]    wrData
);

   localparam int NumRegs = 2**RegAddrWidth;

   logic [WordWidth-1:0] regs [NumRegs];

   // Single write port, all registers zero after reset
   always_ff @(posedge clock or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Two combinational read ports
   assign rsData = regs[rsAddr];
   assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

/* tbChecker.sv */
`default_nettype none

module tbChecker (
   input logic        clock,
   input logic        arstN,
   input logic        awvalid,
   input logic        awready,
   input logic [17:0] awaddr,
   input logic        wvalid,
   input logic        wready,
   input logic [31:0] wdata,
   input logic [3:0]  wstrb,
   input logic        bvalid,
   input logic        bready,
   input logic        arvalid,
   input logic        arready,
   input logic [17:0] araddr,
   input logic        rvalid,
   input logic        rready,
   input logic        halted
);

   logic [15:0] rom [256];
   logic [31:0] refMem [256];
   logic [17:0] expAddr [$];
   logic [15:0] expData [$];
   logic [17:0] expLoad [$];
   int          valueErrors = 0;
   int          protocolErrors = 0;
   int          storeIdx = 0;
   int          loadIdx = 0;
   logic        gotAddr = 1'b0;
   logic        gotData = 1'b0;
   logic [17:0] obsAddr;
   logic [31:0] obsData;
   logic [3:0]  obsStrb;
   logic        seenReq = 1'b0;
   logic        prevHalted = 1'b0;
   // Last cycle's view for stability and hold checks
   logic        pAwvalid = 1'b0;
   logic        pAwready;
   logic        pWvalid = 1'b0;
   logic        pWready;
   logic        pArvalid = 1'b0;
   logic        pArready;
   logic        pBready = 1'b0;
   logic        pBvalid;
   logic        pRready = 1'b0;
   logic        pRvalid;
   logic [17:0] pAwaddr;
   logic [17:0] pAraddr;
   logic [31:0] pWdata;

   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // ==============================
   // Reference ISA model
   // ==============================

   function automatic void runModel();
      logic [7:0]  pc;
      logic [15:0] regs [8];
      logic [15:0] ins;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm;
      logic [15:0] off;
      logic [15:0] addr;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [2:0]  rt;
      bit          done;
      int          steps;
      pc = 8'd0;
      done = 0;
      steps = 0;
      for (int i = 0; i < 8; i++) regs[i] = 16'h0;
      while (!done && steps < 10000) begin
         ins  = rom[pc];
         pc   = pc + 8'd1;
         rd   = ins[11:9];
         rs   = ins[8:6];
         rt   = ins[5:3];
         a    = regs[rs];
         b    = regs[rt];
         imm  = {{8{ins[7]}}, ins[7:0]};
         off  = {{10{ins[5]}}, ins[5:0]};
         addr = regs[rs] + off;
         steps++;
         case (ins[15:12])
            4'h0: regs[rd] = a + b;
            4'h1: regs[rd] = a - b;
            4'h2: regs[rd] = a & b;
            4'h3: regs[rd] = a | b;
            4'h4: regs[rd] = a ^ b;
            4'h5: regs[rd] = a << b[3:0];
            4'h6: regs[rd] = a >> b[3:0];
            // ADDI and LDI
            4'h7: regs[rd] = regs[rd] + imm;
            4'h8: regs[rd] = imm;
            // Load keeps the low half
            4'h9: begin
               regs[rd] = refMem[addr[7:0]][15:0];
               expLoad.push_back({addr, 2'b00});
            end
            4'hA: begin
               refMem[addr[7:0]] = {16'h0, regs[rd]};
               expAddr.push_back({addr, 2'b00});
               expData.push_back(regs[rd]);
            end
            // Branch compares top two fields with offset from next PC
            4'hB: if (regs[rd] == regs[rs]) pc = pc + off[7:0];
            4'hC: if (regs[rd] != regs[rs]) pc = pc + off[7:0];
            4'hD: pc = ins[7:0];
            4'hE: done = 1;
            default: ;
         endcase
      end
   endfunction

   initial begin
      logic [31:0] s;
      for (int i = 0; i < 256; i++) rom[i] = 16'hF000;
      $readmemh("program.hex", rom);
      s = 32'h2e34;
      for (int i = 0; i < 256; i++) begin
         for (int b = 0; b < 32; b++) begin
            s = lfsrNext(s);
            refMem[i][b] = s[0];
         end
      end
      runModel();
   end

   // ==============================
   // Watcher
   // ==============================

   always @(posedge clock) begin
      // Idle outputs until the first request
      if (awvalid || arvalid) seenReq = 1'b1;
      if (!seenReq && (wvalid || bready || rready || halted)) begin
         $display("error %0t: output active before first request", $time);
         protocolErrors++;
      end
      // Stalled payloads must hold
      if (pAwvalid && !pAwready && (!awvalid || awaddr != pAwaddr)) begin
         $display("error %0t: awaddr changed or awvalid dropped while stalled", $time);
         protocolErrors++;
      end
      if (pWvalid && !pWready && (!wvalid || wdata != pWdata)) begin
         $display("error %0t: wdata changed or wvalid dropped while stalled", $time);
         protocolErrors++;
      end
      if (pArvalid && !pArready && (!arvalid || araddr != pAraddr)) begin
         $display("error %0t: araddr changed or arvalid dropped while stalled", $time);
         protocolErrors++;
      end
      // Response ready held until the response arrives
      if (pBready && !pBvalid && !bready) begin
         $display("error %0t: bready dropped before bvalid", $time);
         protocolErrors++;
      end
      if (pRready && !pRvalid && !rready) begin
         $display("error %0t: rready dropped before rvalid", $time);
         protocolErrors++;
      end
      // Each load reads the model's address
      if (arvalid && arready) begin
         if (loadIdx >= expLoad.size()) begin
            $display("error %0t: extra load from %h", $time, araddr);
            valueErrors++;
         end else if (araddr != expLoad[loadIdx]) begin
            $display("error %0t: load %0d from %h, expected %h", $time, loadIdx,
                     araddr, expLoad[loadIdx]);
            valueErrors++;
         end
         loadIdx++;
      end
      // Collect both write halves
      if (awvalid && awready) begin
         gotAddr = 1'b1;
         obsAddr = awaddr;
      end
      if (wvalid && wready) begin
         gotData = 1'b1;
         obsData = wdata;
         obsStrb = wstrb;
      end
      if (gotAddr && gotData) begin
         if (storeIdx >= expAddr.size()) begin
            $display("error %0t: extra store to %h", $time, obsAddr);
            valueErrors++;
         end else if (obsAddr != expAddr[storeIdx] || obsData != {16'h0, expData[storeIdx]}
                      || obsStrb != 4'hF) begin
            $display("error %0t: store %0d got %h=%h strb %h, expected %h=%h", $time,
                     storeIdx, obsAddr, obsData, obsStrb, expAddr[storeIdx],
                     expData[storeIdx]);
            valueErrors++;
         end
         storeIdx++;
         gotAddr = 1'b0;
         gotData = 1'b0;
      end
      // Halt ends the store sequence
      if (halted && !prevHalted && storeIdx != expAddr.size()) begin
         $display("error %0t: %0d stores at halt, expected %0d", $time, storeIdx,
                  expAddr.size());
         valueErrors++;
      end
      if (halted && !prevHalted && loadIdx != expLoad.size()) begin
         $display("error %0t: %0d loads at halt, expected %0d", $time, loadIdx,
                  expLoad.size());
         valueErrors++;
      end
      if (prevHalted && (awvalid || wvalid || arvalid)) begin
         $display("error %0t: AXI valid raised after halt", $time);
         protocolErrors++;
      end
      prevHalted = halted;
      pAwvalid = awvalid;
      pAwready = awready;
      pAwaddr  = awaddr;
      pWvalid  = wvalid;
      pWready  = wready;
      pWdata   = wdata;
      pArvalid = arvalid;
      pArready = arready;
      pAraddr  = araddr;
      pBready  = bready;
      pBvalid  = bvalid;
      pRready  = rready;
      pRvalid  = rvalid;
   end

endmodule

`default_nettype wire

/* tbCpuTop.sv */
`default_nettype none

module tbCpuTop;

   localparam int Timeout = 2000;

   logic        clock;
   logic        arstN;
   logic        awvalid;
   logic        awready;
   logic [17:0] awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        bvalid;
   logic        bready;
   logic        arvalid;
   logic        arready;
   logic [17:0] araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic        halted;

   // Memory model state
   logic [31:0] mem [256];
   logic [31:0] lfsrState;
   logic [1:0]  awWait;
   logic [1:0]  wWait;
   logic [1:0]  bWait;
   logic [1:0]  arWait;
   logic [1:0]  rWait;
   logic        awGot;
   logic        wGot;
   logic        arGot;
   logic [7:0]  wrIdx;
   logic [7:0]  rdIdx;
   logic [31:0] wrWord;
   int          timeouts;
   int          cycles;

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // Wait state of 0 to 3 cycles from two bits
   function automatic logic [1:0] drawDelay();
      logic [1:0] d;
      for (int b = 0; b < 2; b++) begin
         lfsrState = lfsrNext(lfsrState);
         d[b] = lfsrState[0];
      end
      return d;
   endfunction

   always #5 clock = ~clock;

   cpuTop u_cpuTop (
      .clock(clock), .arstN(arstN),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata),
      .halted(halted)
   );

   tbChecker uTbChecker (
      .clock(clock), .arstN(arstN),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
      .bvalid(bvalid), .bready(bready),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready),
      .halted(halted)
   );

   // ==============================
   // AXI4-Lite memory model
   // ==============================

   always @(posedge clock) begin
      if (!arstN) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         awGot   <= 1'b0;
         wGot    <= 1'b0;
         arGot   <= 1'b0;
         awWait  <= 2'd0;
         wWait   <= 2'd0;
         bWait   <= 2'd0;
         arWait  <= 2'd0;
         rWait   <= 2'd0;
      end else begin
         // Write address
         if (awvalid && awready) begin
            awready <= 1'b0;
            awGot   <= 1'b1;
            wrIdx   <= awaddr[9:2];
            awWait  <= drawDelay();
         end else if (awvalid) begin
            if (awWait == 2'd0) awready <= 1'b1;
            else awWait <= awWait - 2'd1;
         end
         // Write data
         if (wvalid && wready) begin
            wready <= 1'b0;
            wGot   <= 1'b1;
            wrWord <= wdata;
            wWait  <= drawDelay();
         end else if (wvalid) begin
            if (wWait == 2'd0) wready <= 1'b1;
            else wWait <= wWait - 2'd1;
         end
         // Write response once both halves are in
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end else if (awGot && wGot && !bvalid) begin
            if (bWait == 2'd0) begin
               bvalid      <= 1'b1;
               mem[wrIdx]  <= wrWord;
               awGot       <= 1'b0;
               wGot        <= 1'b0;
               bWait       <= drawDelay();
            end else begin
               bWait <= bWait - 2'd1;
            end
         end
         // Read address
         if (arvalid && arready) begin
            arready <= 1'b0;
            arGot   <= 1'b1;
            rdIdx   <= araddr[9:2];
            arWait  <= drawDelay();
         end else if (arvalid) begin
            if (arWait == 2'd0) arready <= 1'b1;
            else arWait <= arWait - 2'd1;
         end
         // Read data
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end else if (arGot && !rvalid) begin
            if (rWait == 2'd0) begin
               rvalid <= 1'b1;
               rdata  <= mem[rdIdx];
               arGot  <= 1'b0;
               rWait  <= drawDelay();
            end else begin
               rWait <= rWait - 2'd1;
            end
         end
      end
   end

   // ==============================
   // Sequence
   // ==============================

   initial begin
      logic [31:0] fillWord;
      clock     = 1'b0;
      arstN     <= 1'b0;
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rdata     <= '0;
      timeouts  = 0;
      lfsrState = 32'h2e34;
      // Same fill order as the checker
      for (int i = 0; i < 256; i++) begin
         for (int b = 0; b < 32; b++) begin
            lfsrState = lfsrNext(lfsrState);
            fillWord[b] = lfsrState[0];
         end
         mem[i] <= fillWord;
      end
      repeat (3) @(posedge clock);
      arstN <= 1'b1;
      // Run until the core halts
      cycles = 0;
      while (!halted && cycles < Timeout) begin
         @(posedge clock);
         cycles++;
      end
      if (!halted) begin
         $display("Timeout: the core never raised halted");
         timeouts++;
      end
      // Quiet window after halt
      repeat (20) @(posedge clock);
      @(negedge clock);
      $display("Errors: %0d value, %0d protocol, %0d timeout",
               uTbChecker.valueErrors, uTbChecker.protocolErrors, timeouts);
      if (uTbChecker.valueErrors == 0 && uTbChecker.protocolErrors == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
